//--- hw/uart_reg_pkg.sv
package uart_reg_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // bus geometry
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned addr_width = 6;   // byte offsets 0x00..0x3c
  localparam int unsigned data_width = 32;  // bus word

  ////////////////////////////////////////////////////////////////////////////
  // register offsets
  ////////////////////////////////////////////////////////////////////////////

  // transmit channel
  localparam logic [addr_width-1:0] addr_tx_data  = 6'h00;  // push one byte, wo
  localparam logic [addr_width-1:0] addr_tx_load  = 6'h04;  // fifo fill, ro
  localparam logic [addr_width-1:0] addr_tx_baud  = 6'h08;  // bit time minus one
  localparam logic [addr_width-1:0] addr_tx_level = 6'h10;  // irq below this load

  // receive channel
  localparam logic [addr_width-1:0] addr_rx_data  = 6'h20;  // pop one byte, ro
  localparam logic [addr_width-1:0] addr_rx_load  = 6'h24;  // fifo fill, ro
  localparam logic [addr_width-1:0] addr_rx_baud  = 6'h28;  // bit time minus one
  localparam logic [addr_width-1:0] addr_rx_phase = 6'h2c;  // sample point in bit
  localparam logic [addr_width-1:0] addr_rx_level = 6'h30;  // irq above this load

  // 0x0c, 0x14..0x1c and 0x34..0x3c are holes
  // they read zero and swallow writes

endpackage

//--- hw/uart_line_pkg.sv
package uart_line_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // serial frame
  ////////////////////////////////////////////////////////////////////////////

  // 1 start, 8 data lsb first, 1 stop, no parity
  localparam int unsigned char_width = 8;  // data bits per frame
  localparam int unsigned baud_width = 8;  // divisor and phase registers

  // one bit lasts divisor + 1 clocks

  ////////////////////////////////////////////////////////////////////////////
  // fifo sizing
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned fifo_depth = 32;  // default entries
  localparam int unsigned load_width = 6;   // holds 0..fifo_depth

endpackage

//--- hw/uart_fifo.sv
module uart_fifo #(
  parameter int unsigned depth = uart_line_pkg::fifo_depth  // entries
)(
  input  logic                                 tcb,
  input  logic                                 reset,
  // write side stream
  input  logic                                 in_valid,
  input  logic [uart_line_pkg::char_width-1:0] in_data,
  output logic                                 in_ready,   // not full
  // read side stream
  output logic                                 out_valid,  // not empty
  output logic [uart_line_pkg::char_width-1:0] out_data,
  input  logic                                 out_ready,
  // fill level
  output logic [uart_line_pkg::load_width-1:0] load
);

  import uart_line_pkg::*;

  logic [char_width-1:0]     mem [depth];  // storage, no reset
  logic [$clog2(depth)-1:0]  wr_ptr;
  logic [$clog2(depth)-1:0]  rd_ptr;
  logic                      push;
  logic                      pop;

  ////////////////////////////////////////////////////////////////////////////
  // handshakes
  ////////////////////////////////////////////////////////////////////////////

  assign in_ready  = (load != load_width'(depth));
  assign out_valid = (load != '0);

  assign push = in_valid  & in_ready;   // full drops here
  assign pop  = out_valid & out_ready;  // empty pops nothing

  // head entry, combinational
  assign out_data = mem[rd_ptr];

  ////////////////////////////////////////////////////////////////////////////
  // storage and pointers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge tcb) begin
    if (push) mem[wr_ptr] <= in_data;
  end

  always_ff @(posedge tcb) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        // wrap explicitly, depth need not be a power of two
        wr_ptr <= (int'(wr_ptr) == depth - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (int'(rd_ptr) == depth - 1) ? '0 : rd_ptr + 1'b1;
      end
    end
  end

  // load count, steady when push and pop coincide
  always_ff @(posedge tcb) begin
    if (reset) begin
      load <= '0;
    end else if (push && !pop) begin
      load <= load + 1'b1;
    end else if (pop && !push) begin
      load <= load - 1'b1;
    end
  end

endmodule

//--- hw/uart_ser.sv
module uart_ser (
  input  logic                                 tcb,
  input  logic                                 reset,
  // bit time minus one
  input  logic [uart_line_pkg::baud_width-1:0] divisor,
  // byte stream from the tx fifo
  input  logic                                 in_valid,
  input  logic [uart_line_pkg::char_width-1:0] in_data,
  output logic                                 in_ready,
  // serial line, idles high
  output logic                                 txd
);

  import uart_line_pkg::*;

  logic                  busy;      // frame in flight
  logic [baud_width-1:0] baud_cnt;  // counts down to next bit
  logic [3:0]            bit_cnt;   // 0 start, 1..8 data, 9 stop
  logic [char_width:0]   shift;     // data bits then stop, lsb out first
  logic                  accept;

  // only take a byte while the line is idle
  assign in_ready = ~busy;
  assign accept   = in_valid & in_ready;

  ////////////////////////////////////////////////////////////////////////////
  // control
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge tcb) begin
    if (reset) begin
      busy     <= 1'b0;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      txd      <= 1'b1;  // line idle
    end else if (!busy) begin
      if (accept) begin
        busy     <= 1'b1;
        baud_cnt <= divisor;
        bit_cnt  <= '0;
        txd      <= 1'b0;  // start bit goes out on the accept edge
      end
    end else if (baud_cnt != '0) begin
      baud_cnt <= baud_cnt - 1'b1;  // still inside the bit
    end else begin
      baud_cnt <= divisor;
      if (bit_cnt == 4'd9) begin
        busy <= 1'b0;  // stop bit done, txd already high
      end else begin
        bit_cnt <= bit_cnt + 1'b1;
        txd     <= shift[0];  // next data bit or stop
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // shift register
  ////////////////////////////////////////////////////////////////////////////

  // payload only, no reset needed
  always_ff @(posedge tcb) begin
    if (accept) begin
      shift <= {1'b1, in_data};  // stop bit sits above the msb
    end else if (busy && baud_cnt == '0 && bit_cnt != 4'd9) begin
      shift <= {1'b1, shift[char_width:1]};  // ones fill behind
    end
  end

endmodule

//--- hw/uart_des.sv
module uart_des (
  input  logic                                 tcb,
  input  logic                                 reset,
  // bit time minus one and sample point within a bit
  input  logic [uart_line_pkg::baud_width-1:0] divisor,
  input  logic [uart_line_pkg::baud_width-1:0] phase,
  // serial line, asynchronous
  input  logic                                 rxd,
  // received byte, one cycle pulse
  output logic                                 out_valid,
  output logic [uart_line_pkg::char_width-1:0] out_data
);

  import uart_line_pkg::*;

  logic                  rxd_meta;   // first sync stage
  logic                  rxd_sync;   // second sync stage
  logic                  rxd_prev;   // for edge detect
  logic                  fall;
  logic                  busy;       // frame in progress
  logic [baud_width-1:0] baud_cnt;   // cycle within bit, counts up
  logic [3:0]            bit_cnt;    // 0 start, 1..8 data, 9 stop
  logic [char_width-1:0] shift;      // data assembled lsb first
  logic                  sample;     // sample point reached
  logic                  bit_end;    // last cycle of a bit

  ////////////////////////////////////////////////////////////////////////////
  // input synchronizer and start detect
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge tcb) begin
    if (reset) begin
      rxd_meta <= 1'b1;  // idle level
      rxd_sync <= 1'b1;
      rxd_prev <= 1'b1;
    end else begin
      rxd_meta <= rxd;
      rxd_sync <= rxd_meta;
      rxd_prev <= rxd_sync;
    end
  end

  assign fall = rxd_prev & ~rxd_sync;  // high to low on synced line

  ////////////////////////////////////////////////////////////////////////////
  // bit timing
  ////////////////////////////////////////////////////////////////////////////

  assign sample  = busy & (baud_cnt == phase);
  assign bit_end = (baud_cnt == divisor);

  always_ff @(posedge tcb) begin
    if (reset) begin
      busy      <= 1'b0;
      baud_cnt  <= '0;
      bit_cnt   <= '0;
      out_valid <= 1'b0;
    end else begin
      out_valid <= 1'b0;  // pulse by default
      if (!busy) begin
        if (fall) begin
          busy     <= 1'b1;
          baud_cnt <= '0;
          bit_cnt  <= '0;
        end
      end else begin
        // advance in-bit counter
        if (bit_end) begin
          baud_cnt <= '0;
          bit_cnt  <= bit_cnt + 1'b1;
        end else begin
          baud_cnt <= baud_cnt + 1'b1;
        end
        if (sample && bit_cnt == 4'd0 && rxd_sync) begin
          busy <= 1'b0;  // glitch, not a real start bit
        end
        if (sample && bit_cnt == 4'd9) begin
          busy      <= 1'b0;
          out_valid <= rxd_sync;  // low stop bit drops the byte
        end
        // phase beyond divisor never samples, give up after stop slot
        if (bit_end && bit_cnt == 4'd9) busy <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // data capture
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge tcb) begin
    if (sample && bit_cnt >= 4'd1 && bit_cnt <= 4'd8) begin
      shift <= {rxd_sync, shift[char_width-1:1]};  // lsb arrives first
    end
  end

  assign out_data = shift;  // stable until next frame's first data bit

endmodule

//--- hw/uart_ctrl.sv
module uart_ctrl (
  input  logic                                 tcb,
  input  logic                                 reset,
  // register bus, always ready
  input  logic                                 req,        // one cycle strobe
  input  logic                                 req_write,
  input  logic [uart_reg_pkg::addr_width-1:0]  req_addr,
  input  logic [uart_reg_pkg::data_width-1:0]  req_wdata,
  output logic [uart_reg_pkg::data_width-1:0]  rsp_rdata,  // same cycle
  // serial lines
  input  logic                                 rxd,
  output logic                                 txd,
  // interrupts
  output logic                                 irq_tx,     // tx load below level
  output logic                                 irq_rx      // rx load above level
);

  import uart_reg_pkg::*;
  import uart_line_pkg::*;

  // configuration registers
  logic [baud_width-1:0] tx_baud;
  logic [load_width-1:0] tx_level;
  logic [baud_width-1:0] rx_baud;
  logic [baud_width-1:0] rx_phase;
  logic [load_width-1:0] rx_level;

  // bus decode
  logic                  bus_write;
  logic                  bus_read;

  // tx channel
  logic                  tx_push;   // bus write into fifo
  logic                  tx_room;   // fifo not full
  logic                  tx_valid;  // fifo to serializer
  logic [char_width-1:0] tx_data;
  logic                  tx_ready;
  logic [load_width-1:0] tx_load;

  // rx channel
  logic                  rx_valid;  // deserializer to fifo
  logic [char_width-1:0] rx_data;
  logic                  rx_room;
  logic                  rx_pop;    // bus read out of fifo
  logic                  rx_avail;  // fifo not empty
  logic [char_width-1:0] rx_head;
  logic [load_width-1:0] rx_load;

  ////////////////////////////////////////////////////////////////////////////
  // bus access
  ////////////////////////////////////////////////////////////////////////////

  assign bus_write = req &  req_write;
  assign bus_read  = req & ~req_write;

  assign tx_push = bus_write & (req_addr == addr_tx_data) & tx_room;  // full drops
  assign rx_pop  = bus_read  & (req_addr == addr_rx_data);

  // read mux, decoded from address alone
  always_comb begin
    case (req_addr)
      addr_tx_load:  rsp_rdata = data_width'(tx_load);
      addr_tx_baud:  rsp_rdata = data_width'(tx_baud);
      addr_tx_level: rsp_rdata = data_width'(tx_level);
      addr_rx_data:  rsp_rdata = rx_avail ? data_width'(rx_head) : '0;  // empty reads 0
      addr_rx_load:  rsp_rdata = data_width'(rx_load);
      addr_rx_baud:  rsp_rdata = data_width'(rx_baud);
      addr_rx_phase: rsp_rdata = data_width'(rx_phase);
      addr_rx_level: rsp_rdata = data_width'(rx_level);
      default:       rsp_rdata = '0;  // tx data is write only, holes too
    endcase
  end

  // config writes, truncated to register width
  always_ff @(posedge tcb) begin
    if (reset) begin
      tx_baud  <= '0;
      tx_level <= '0;
      rx_baud  <= '0;
      rx_phase <= '0;
      rx_level <= '0;
    end else if (bus_write) begin
      case (req_addr)
        addr_tx_baud:  tx_baud  <= req_wdata[baud_width-1:0];
        addr_tx_level: tx_level <= req_wdata[load_width-1:0];
        addr_rx_baud:  rx_baud  <= req_wdata[baud_width-1:0];
        addr_rx_phase: rx_phase <= req_wdata[baud_width-1:0];
        addr_rx_level: rx_level <= req_wdata[load_width-1:0];
        default: ;  // data, status and holes ignored
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // tx channel
  ////////////////////////////////////////////////////////////////////////////

  uart_fifo #(
    .depth     (fifo_depth)
  ) u_tx_fifo (
    .tcb       (tcb),
    .reset     (reset),
    .in_valid  (tx_push),
    .in_data   (req_wdata[char_width-1:0]),
    .in_ready  (tx_room),
    .out_valid (tx_valid),
    .out_data  (tx_data),
    .out_ready (tx_ready),
    .load      (tx_load)
  );

  uart_ser u_ser (
    .tcb       (tcb),
    .reset     (reset),
    .divisor   (tx_baud),
    .in_valid  (tx_valid),
    .in_data   (tx_data),
    .in_ready  (tx_ready),  // held off while a frame is out
    .txd       (txd)
  );

  assign irq_tx = (tx_load < tx_level);  // level 0 keeps it quiet

  ////////////////////////////////////////////////////////////////////////////
  // rx channel
  ////////////////////////////////////////////////////////////////////////////

  uart_des u_des (
    .tcb       (tcb),
    .reset     (reset),
    .divisor   (rx_baud),
    .phase     (rx_phase),
    .rxd       (rxd),
    .out_valid (rx_valid),
    .out_data  (rx_data)
  );

  uart_fifo #(
    .depth     (fifo_depth)
  ) u_rx_fifo (
    .tcb       (tcb),
    .reset     (reset),
    .in_valid  (rx_valid & rx_room),  // no back-pressure, full drops the byte
    .in_data   (rx_data),
    .in_ready  (rx_room),
    .out_valid (rx_avail),
    .out_data  (rx_head),
    .out_ready (rx_pop),
    .load      (rx_load)
  );

  assign irq_rx = (rx_load > rx_level);

endmodule

//--- tb/uart_ctrl_properties.sv
module uart_ctrl_properties (
  input logic                                 tcb,
  input logic                                 reset,
  input logic                                 txd,
  input logic                                 rx_valid,
  input logic [uart_line_pkg::load_width-1:0] tx_load,
  input logic [uart_line_pkg::load_width-1:0] rx_load
);

  timeunit 1ns;
  timeprecision 1ps;

  import uart_line_pkg::*;

  // line idles high through reset and right after it
  assert property (@(posedge tcb) reset |=> txd)
    else $error("txd not high during or just after reset");

  assert property (@(posedge tcb) disable iff (reset) tx_load <= load_width'(fifo_depth))
    else $error("tx fifo load above its depth");
  assert property (@(posedge tcb) disable iff (reset) rx_load <= load_width'(fifo_depth))
    else $error("rx fifo load above its depth");

  // deserializer emits single cycle pulses only
  assert property (@(posedge tcb) disable iff (reset) rx_valid |=> !rx_valid)
    else $error("rx valid held high for two cycles");

endmodule

bind uart_ctrl uart_ctrl_properties u_props (
  .tcb      (tcb),
  .reset    (reset),
  .txd      (txd),
  .rx_valid (rx_valid),
  .tx_load  (tx_load),
  .rx_load  (rx_load)
);

//--- tb/uart_ctrl_checker.sv
module uart_ctrl_checker (
  input logic                                tcb,
  input logic                                reset,
  input logic                                req,
  input logic                                req_write,
  input logic [uart_reg_pkg::addr_width-1:0] req_addr,
  input logic [uart_reg_pkg::data_width-1:0] req_wdata,
  input logic [uart_reg_pkg::data_width-1:0] rsp_rdata,
  input logic                                rxd,
  input logic                                txd,
  input logic                                irq_tx,
  input logic                                irq_rx
);

  timeunit 1ns;
  timeprecision 1ps;

  import uart_reg_pkg::*;
  import uart_line_pkg::*;

  int error_count = 0;
  int test_errors = 0;
  int tests_run   = 0;
  logic [7:0] tx_baud, rx_baud, rx_phase;  // model config
  logic [5:0] tx_level, rx_level;
  logic [7:0] tx_fifo [$];    // queued in the tx fifo
  logic [7:0] tx_expect [$];  // handed to the serializer but not yet seen on txd
  logic [7:0] rx_fifo [$];
  int         ser_timer, tx_k, rx_k, push_cnt;
  logic       tx_act, rx_act, tx_prev, rx_prev;
  logic [7:0] tx_byte, rx_byte;
  logic       tx_idle, rx_busy;    // polled by the testbench

  function automatic logic [31:0] expected(input logic [5:0] addr);
    case (addr)
      addr_tx_load:  return 32'(tx_fifo.size());
      addr_tx_baud:  return 32'(tx_baud);
      addr_tx_level: return 32'(tx_level);
      addr_rx_data:  return (rx_fifo.size() != 0) ? 32'(rx_fifo[0]) : 32'h0;
      addr_rx_load:  return 32'(rx_fifo.size());
      addr_rx_baud:  return 32'(rx_baud);
      addr_rx_phase: return 32'(rx_phase);
      addr_rx_level: return 32'(rx_level);
      default:       return 32'h0;  // tx data and holes
    endcase
  endfunction

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("mismatch at %0t: %s expected %0h actual %0h", $time, name, exp, act);
      error_count++;
      test_errors++;
    end
  endtask

  task automatic report_test(input string name);
    $display("test %s %s, %0d errors", name,
             (test_errors == 0) ? "ok" : "FAILED", test_errors);
    tests_run++;
    test_errors = 0;
  endtask

  task automatic report_totals();
    $display("tests run %0d, errors %0d", tests_run, error_count);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // cycle model against pre-edge state
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge tcb) begin : model
    logic full;
    logic rx_full;
    int   d, p, b;
    if (reset) begin
      {tx_baud, rx_baud, rx_phase, tx_level, rx_level} = '0;
      tx_fifo.delete();
      tx_expect.delete();
      rx_fifo.delete();
      {ser_timer, tx_k, rx_k, push_cnt} = '0;
      {tx_act, rx_act} = 2'b00;
      {tx_prev, rx_prev} = 2'b11;
    end else begin
      if (req && !req_write) check("rsp_rdata", expected(req_addr), rsp_rdata);
      check("irq_tx", 32'(tx_fifo.size() < int'(tx_level)), 32'(irq_tx));
      check("irq_rx", 32'(rx_fifo.size() > int'(rx_level)), 32'(irq_rx));
      // fullness as seen before this edge's pops
      full    = (tx_fifo.size() == int'(fifo_depth));
      rx_full = (rx_fifo.size() == int'(fifo_depth));
      // serializer takes the head only when idle and before this edge's push
      if (ser_timer != 0) ser_timer--;
      else if (tx_fifo.size() != 0) begin
        tx_expect.push_back(tx_fifo.pop_front());
        ser_timer = 10 * (int'(tx_baud) + 1);  // whole frame
      end
      if (req && req_write) begin
        case (req_addr)
          addr_tx_data:  if (!full) tx_fifo.push_back(req_wdata[7:0]);  // full drops
          addr_tx_baud:  tx_baud  = req_wdata[7:0];
          addr_tx_level: tx_level = req_wdata[5:0];
          addr_rx_baud:  rx_baud  = req_wdata[7:0];
          addr_rx_phase: rx_phase = req_wdata[7:0];
          addr_rx_level: rx_level = req_wdata[5:0];
          default: ;
        endcase
      end
      if (req && !req_write && req_addr == addr_rx_data && rx_fifo.size() != 0)
        void'(rx_fifo.pop_front());
      // byte lands in the fifo 3 edges after the stop sample
      if (push_cnt != 0) begin
        push_cnt--;
        if (push_cnt == 0 && !rx_full) rx_fifo.push_back(rx_byte);
      end
      // txd decode at mid-bit
      d = int'(tx_baud) + 1;
      if (!tx_act) begin
        if (tx_prev && !txd) begin
          tx_act = 1'b1;
          tx_k   = 0;
        end
      end else begin
        tx_k++;
        if (tx_k % d == d / 2) begin
          b = tx_k / d;
          if (b >= 1 && b <= 8) tx_byte = {txd, tx_byte[7:1]};
          if (b == 9) begin
            tx_act = 1'b0;
            if (!txd) begin
              $display("error at %0t: txd stop bit low", $time);
              error_count++;
              test_errors++;
            end
            if (tx_expect.size() == 0) begin
              $display("error at %0t: frame on txd with no byte queued", $time);
              error_count++;
              test_errors++;
            end else check("txd byte", 32'(tx_expect.pop_front()), 32'(tx_byte));
          end
        end
      end
      // rxd model with the 2 cycle sync lag folded into the +1
      d = int'(rx_baud) + 1;
      p = int'(rx_phase);
      if (!rx_act) begin
        if (rx_prev && !rxd) begin
          rx_act = 1'b1;
          rx_k   = 0;
        end
      end else begin
        rx_k++;
        if (rx_k >= 1 + p && (rx_k - 1 - p) % d == 0) begin
          b = (rx_k - 1 - p) / d;
          if (b == 0 && rxd) rx_act = 1'b0;  // false start
          else if (b >= 1 && b <= 8) rx_byte = {rxd, rx_byte[7:1]};
          else if (b == 9) begin
            rx_act = 1'b0;
            if (rxd) push_cnt = 3;  // low stop drops the byte
          end
        end
      end
      tx_prev = txd;
      rx_prev = rxd;
    end
    tx_idle = (tx_fifo.size() == 0) && (ser_timer == 0) && !tx_act && (tx_expect.size() == 0);
    rx_busy = rx_act || (push_cnt != 0);
  end

endmodule

//--- tb/uart_ctrl_tb.sv
module uart_ctrl_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import uart_reg_pkg::*;

  localparam int n_frames = 80;                      // frames over all tests
  localparam int limit    = n_frames * 10 * 21 + 2000;  // divisor at most 20

  logic        tcb, reset, req, req_write, rx_line, loop_en;
  logic [5:0]  req_addr, a;
  logic [31:0] req_wdata, rsp_rdata;
  logic        rxd, txd, irq_tx, irq_rx;
  integer      seed = 30764;
  int          cycles = 0;
  int          d;

  assign rxd = loop_en ? txd : rx_line;  // loopback tap

  uart_ctrl u_dut (.*);
  uart_ctrl_checker u_checker (.*);

  initial begin
    tcb = 1'b0;
    forever #10 tcb = ~tcb;
  end

  always @(posedge tcb) begin
    cycles <= cycles + 1;
    if (cycles == limit) begin
      $display("timeout after %0d cycles, the DUT never finished the tests", cycles);
      $display("sim failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // bus and line tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic bus_write(input logic [5:0] addr, input logic [31:0] data);
    @(posedge tcb);
    req       <= 1'b1;
    req_write <= 1'b1;
    req_addr  <= addr;
    req_wdata <= data;
    @(posedge tcb);
    req <= 1'b0;
  endtask

  task automatic bus_read(input logic [5:0] addr);
    @(posedge tcb);
    req       <= 1'b1;
    req_write <= 1'b0;
    req_addr  <= addr;
    @(posedge tcb);
    req <= 1'b0;  // checker compares rsp_rdata
  endtask

  task automatic send_frame(input logic [7:0] data, input logic stop, input int div);
    logic [9:0] bits;
    bits = {stop, data, 1'b0};  // lsb first after start
    for (int i = 0; i < 10; i++) begin
      rx_line <= bits[i];
      repeat (div + 1) @(posedge tcb);
    end
    rx_line <= 1'b1;
    repeat (div + 1) @(posedge tcb);  // idle gap
  endtask

  task automatic wait_tx();
    do @(negedge tcb); while (!u_checker.tx_idle);
  endtask

  task automatic drain_rx();
    do @(negedge tcb); while (u_checker.rx_busy);
    while (u_checker.rx_fifo.size() != 0) begin
      bus_read(addr_rx_load);
      bus_read(addr_rx_data);
      @(negedge tcb);
    end
    bus_read(addr_rx_data);  // empty reads zero
  endtask

  task automatic close_test(input string name);
    @(negedge tcb);  // let the checker finish this edge
    u_checker.report_test(name);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    req       = 1'b0;
    req_write = 1'b0;
    req_addr  = '0;
    req_wdata = '0;
    rx_line   = 1'b1;
    loop_en   = 1'b0;
    reset     = 1'b1;
    repeat (10) @(posedge tcb);
    reset <= 1'b0;

    for (int i = 0; i < 16; i++) bus_read(6'(i * 4));  // every slot incl holes
    close_test("reset");

    repeat (24) begin
      a = 6'($random(seed)) & 6'h3c;
      if (a == addr_tx_data) a = addr_tx_baud;  // no pushes here
      bus_write(a, $random(seed));
      bus_read(a);
    end
    bus_write(addr_tx_level, 0);
    bus_write(addr_rx_level, 0);
    close_test("registers");

    for (int r = 0; r < 3; r++) begin
      d = 3 + int'({$random(seed)} % 18);
      bus_write(addr_tx_baud, d);
      repeat ((r == 0) ? 40 : 5) bus_write(addr_tx_data, $random(seed));  // 40 overflows
      bus_read(addr_tx_load);  // fill while the serializer is busy
      wait_tx();
    end
    close_test("transmit");

    d = 3 + int'({$random(seed)} % 18);
    bus_write(addr_rx_baud, d);
    bus_write(addr_rx_phase, d / 2);
    for (int i = 0; i < 6; i++) send_frame(8'($random(seed)), i != 3, d);
    drain_rx();
    close_test("receive");

    bus_write(addr_tx_level, {$random(seed)} % 8);
    bus_write(addr_rx_level, {$random(seed)} % 4);
    repeat (4) bus_write(addr_tx_data, $random(seed));
    for (int i = 0; i < 4; i++) send_frame(8'($random(seed)), 1'b1, d);
    wait_tx();
    drain_rx();
    close_test("interrupts");

    d = 3 + int'({$random(seed)} % 18);
    bus_write(addr_tx_baud, d);
    bus_write(addr_rx_baud, d);
    bus_write(addr_rx_phase, d / 2);
    loop_en <= 1'b1;
    repeat (8) bus_write(addr_tx_data, $random(seed));
    wait_tx();
    drain_rx();
    close_test("loopback");

    u_checker.report_totals();
    if (u_checker.error_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- flist.f
hw/uart_reg_pkg.sv
hw/uart_line_pkg.sv
hw/uart_fifo.sv
hw/uart_ser.sv
hw/uart_des.sv
hw/uart_ctrl.sv
tb/uart_ctrl_properties.sv
tb/uart_ctrl_checker.sv
tb/uart_ctrl_tb.sv

//--- Makefile
TOP = uart_ctrl_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f flist.f \
		--top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) > sim.log 2>&1 || echo "sim failed" >> sim.log
	cat sim.log
	! grep -q "sim failed" sim.log

clean:
	rm -rf obj_dir sim.log
